/* source/uart_alu_pkg.sv */
package uart_alu_pkg;

   ////////////////////////////////////////////////////////////
   // Data path widths
   ////////////////////////////////////////////////////////////

   // One UART byte
   localparam int NB_DATA = 8;
   // Operation code, low bits of the third byte
   localparam int NB_OP   = 6;

   ////////////////////////////////////////////////////////////
   // Baud timing
   ////////////////////////////////////////////////////////////

   // System clocks per oversampling tick
   // Use 163 for 19,200 baud at 50 MHz
   localparam int BAUD_DIVISOR = 4;
   // Divider counter width
   localparam int NB_BAUD_CNT  = 8;
   // Ticks per bit
   localparam int OVERSAMPLE   = 16;
   // Ticks in the stop bit
   localparam int STOP_TICKS   = 16;
   // Tick counter width inside one bit
   localparam int NB_TICK_CNT  = $clog2(OVERSAMPLE);
   // Data bit index width
   localparam int NB_BIT_CNT   = $clog2(NB_DATA);

   ////////////////////////////////////////////////////////////
   // Operation codes
   ////////////////////////////////////////////////////////////

   // Arithmetic
   localparam logic [NB_OP-1:0] OP_ADD = 6'b100000;
   localparam logic [NB_OP-1:0] OP_SUB = 6'b100010;
   // Bitwise logic
   localparam logic [NB_OP-1:0] OP_AND = 6'b100100;
   localparam logic [NB_OP-1:0] OP_OR  = 6'b100101;
   localparam logic [NB_OP-1:0] OP_XOR = 6'b100110;
   localparam logic [NB_OP-1:0] OP_NOR = 6'b100111;
   // Shifts, amount from b
   localparam logic [NB_OP-1:0] OP_SRA = 6'b000011;
   localparam logic [NB_OP-1:0] OP_SRL = 6'b000010;

   ////////////////////////////////////////////////////////////
   // Request from sequencer to ALU
   ////////////////////////////////////////////////////////////

   // First received byte in a, second in b, third in op
   typedef struct packed {
      logic [NB_DATA-1:0] a;
      logic [NB_DATA-1:0] b;
      logic [NB_OP-1:0]   op;
   } alu_req_t;

endpackage

/* source/baud_tick_gen.sv */
`timescale 1ns/10ps

module baud_tick_gen (
   input  logic i_clk,
   input  logic i_rst_n,
   output logic o_tick
);

   import uart_alu_pkg::*;

   // Free running divider count
   logic [NB_BAUD_CNT-1:0] baud_cnt;
   // Last count before wrap
   logic                   cnt_wrap;

   assign cnt_wrap = (baud_cnt == NB_BAUD_CNT'(BAUD_DIVISOR - 1));

   // Counter wraps every BAUD_DIVISOR clocks
   // Tick is registered, one clock wide
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         baud_cnt <= '0;
         o_tick   <= 1'b0;
      end else begin
         o_tick <= cnt_wrap;
         if (cnt_wrap) begin
            baud_cnt <= '0;
         end else begin
            baud_cnt <= baud_cnt + 1'b1;
         end
      end
   end

endmodule

/* source/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx (
   input  logic                             i_clk,
   input  logic                             i_rst_n,
   input  logic                             i_tick,
   input  logic                             i_rx,
   output logic [uart_alu_pkg::NB_DATA-1:0] o_data,
   output logic                             o_done
);

   import uart_alu_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_START,
      ST_DATA,
      ST_STOP
   } rx_state_t;

   rx_state_t              state;
   rx_state_t              state_next;
   logic [NB_TICK_CNT-1:0] s_cnt;
   logic [NB_TICK_CNT-1:0] s_cnt_next;
   logic [NB_BIT_CNT-1:0]  n_cnt;
   logic [NB_BIT_CNT-1:0]  n_cnt_next;
   logic [NB_DATA-1:0]     shift;
   logic [NB_DATA-1:0]     shift_next;
   logic                   done_next;
   // Two flop line synchronizer
   logic                   rx_meta;
   logic                   rx_sync;

   ////////////////////////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////////////////////////

   // Line idles high, so the synchronizer resets high
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         state   <= ST_IDLE;
         s_cnt   <= '0;
         n_cnt   <= '0;
         o_done  <= 1'b0;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
         state   <= state_next;
         s_cnt   <= s_cnt_next;
         n_cnt   <= n_cnt_next;
         o_done  <= done_next;
      end
   end

   // Shift register and output byte
   always_ff @(posedge i_clk) begin
      shift <= shift_next;
      if (done_next) begin
         o_data <= shift;
      end
   end

   ////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_next = state;
      s_cnt_next = s_cnt;
      n_cnt_next = n_cnt;
      shift_next = shift;
      done_next  = 1'b0;
      case (state)
         // Wait for falling edge
         ST_IDLE: begin
            if (!rx_sync) begin
               state_next = ST_START;
               s_cnt_next = '0;
            end
         end
         // Half a bit to mid start, drop glitches there
         ST_START: begin
            if (i_tick) begin
               if (s_cnt == NB_TICK_CNT'(OVERSAMPLE / 2 - 1)) begin
                  if (rx_sync) begin
                     state_next = ST_IDLE;
                  end else begin
                     state_next = ST_DATA;
                     s_cnt_next = '0;
                     n_cnt_next = '0;
                  end
               end else begin
                  s_cnt_next = s_cnt + 1'b1;
               end
            end
         end
         // One sample per bit, LSB first
         ST_DATA: begin
            if (i_tick) begin
               if (s_cnt == NB_TICK_CNT'(OVERSAMPLE - 1)) begin
                  s_cnt_next = '0;
                  shift_next = {rx_sync, shift[NB_DATA-1:1]};
                  if (n_cnt == NB_BIT_CNT'(NB_DATA - 1)) begin
                     state_next = ST_STOP;
                  end else begin
                     n_cnt_next = n_cnt + 1'b1;
                  end
               end else begin
                  s_cnt_next = s_cnt + 1'b1;
               end
            end
         end
         // Mid stop sample, a low stop bit loses the frame
         ST_STOP: begin
            if (i_tick) begin
               if (s_cnt == NB_TICK_CNT'(STOP_TICKS - 1)) begin
                  state_next = ST_IDLE;
                  done_next  = rx_sync;
               end else begin
                  s_cnt_next = s_cnt + 1'b1;
               end
            end
         end
         default: state_next = ST_IDLE;
      endcase
   end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx (
   input  logic                             i_clk,
   input  logic                             i_rst_n,
   input  logic                             i_tick,
   input  logic                             i_start,
   input  logic [uart_alu_pkg::NB_DATA-1:0] i_data,
   output logic                             o_tx,
   output logic                             o_busy
);

   import uart_alu_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_START,
      ST_DATA,
      ST_STOP
   } tx_state_t;

   tx_state_t              state;
   tx_state_t              state_next;
   logic [NB_TICK_CNT-1:0] s_cnt;
   logic [NB_TICK_CNT-1:0] s_cnt_next;
   logic [NB_BIT_CNT-1:0]  n_cnt;
   logic [NB_BIT_CNT-1:0]  n_cnt_next;
   logic [NB_DATA-1:0]     shift;
   logic [NB_DATA-1:0]     shift_next;
   logic                   tx_next;

   // Busy for the whole frame
   assign o_busy = (state != ST_IDLE);

   // Line register, high out of reset
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= ST_IDLE;
         s_cnt <= '0;
         n_cnt <= '0;
         o_tx  <= 1'b1;
      end else begin
         state <= state_next;
         s_cnt <= s_cnt_next;
         n_cnt <= n_cnt_next;
         o_tx  <= tx_next;
      end
   end

   always_ff @(posedge i_clk) begin
      shift <= shift_next;
   end

   always_comb begin
      state_next = state;
      s_cnt_next = s_cnt;
      n_cnt_next = n_cnt;
      shift_next = shift;
      tx_next    = o_tx;
      case (state)
         // Latch byte and drop the line
         ST_IDLE: begin
            tx_next = 1'b1;
            if (i_start) begin
               state_next = ST_START;
               s_cnt_next = '0;
               shift_next = i_data;
               tx_next    = 1'b0;
            end
         end
         // Start bit, then put out bit 0
         ST_START: begin
            if (i_tick) begin
               if (s_cnt == NB_TICK_CNT'(OVERSAMPLE - 1)) begin
                  state_next = ST_DATA;
                  s_cnt_next = '0;
                  n_cnt_next = '0;
                  tx_next    = shift[0];
               end else begin
                  s_cnt_next = s_cnt + 1'b1;
               end
            end
         end
         ST_DATA: begin
            if (i_tick) begin
               if (s_cnt == NB_TICK_CNT'(OVERSAMPLE - 1)) begin
                  s_cnt_next = '0;
                  shift_next = shift >> 1;
                  // Last data bit done, go to stop level
                  if (n_cnt == NB_BIT_CNT'(NB_DATA - 1)) begin
                     state_next = ST_STOP;
                     tx_next    = 1'b1;
                  end else begin
                     n_cnt_next = n_cnt + 1'b1;
                     tx_next    = shift[1];
                  end
               end else begin
                  s_cnt_next = s_cnt + 1'b1;
               end
            end
         end
         // Hold stop level
         ST_STOP: begin
            if (i_tick) begin
               if (s_cnt == NB_TICK_CNT'(STOP_TICKS - 1)) begin
                  state_next = ST_IDLE;
               end else begin
                  s_cnt_next = s_cnt + 1'b1;
               end
            end
         end
         default: state_next = ST_IDLE;
      endcase
   end

endmodule

/* source/alu_cmd_fsm.sv */
`timescale 1ns/10ps

module alu_cmd_fsm (
   input  logic                             i_clk,
   input  logic                             i_rst_n,
   input  logic [uart_alu_pkg::NB_DATA-1:0] i_rx_data,
   input  logic                             i_rx_done,
   input  logic [uart_alu_pkg::NB_DATA-1:0] i_result,
   input  logic                             i_tx_busy,
   output uart_alu_pkg::alu_req_t           o_req,
   output logic                             o_tx_start,
   output logic [uart_alu_pkg::NB_DATA-1:0] o_tx_data
);

   import uart_alu_pkg::*;

   typedef enum logic [1:0] {
      ST_WAIT_A,
      ST_WAIT_B,
      ST_WAIT_OP,
      ST_LAUNCH
   } seq_state_t;

   seq_state_t state;
   // Next operand A came in while the reply waited
   logic       a_pending;
   // Reply goes out this cycle
   logic       launch;

   assign launch = (state == ST_LAUNCH) && !i_tx_busy;

   ////////////////////////////////////////////////////////////
   // Sequence control
   ////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state      <= ST_WAIT_A;
         a_pending  <= 1'b0;
         o_tx_start <= 1'b0;
      end else begin
         o_tx_start <= launch;
         case (state)
            ST_WAIT_A: begin
               if (i_rx_done) begin
                  state <= ST_WAIT_B;
               end
            end
            ST_WAIT_B: begin
               if (i_rx_done) begin
                  state <= ST_WAIT_OP;
               end
            end
            ST_WAIT_OP: begin
               if (i_rx_done) begin
                  state <= ST_LAUNCH;
               end
            end
            // Skip ahead if A already arrived
            ST_LAUNCH: begin
               if (launch) begin
                  a_pending <= 1'b0;
                  state     <= (a_pending || i_rx_done) ? ST_WAIT_B : ST_WAIT_A;
               end else if (i_rx_done) begin
                  a_pending <= 1'b1;
               end
            end
            default: state <= ST_WAIT_A;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Operand and reply registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rx_done) begin
         case (state)
            ST_WAIT_A, ST_LAUNCH: o_req.a <= i_rx_data;
            ST_WAIT_B:            o_req.b <= i_rx_data;
            // Only the low bits carry the opcode
            ST_WAIT_OP:           o_req.op <= i_rx_data[NB_OP-1:0];
            default:              o_req.a <= i_rx_data;
         endcase
      end
      if (launch) begin
         o_tx_data <= i_result;
      end
   end

endmodule

/* source/alu.sv */
`timescale 1ns/10ps

module alu (
   input  uart_alu_pkg::alu_req_t           i_req,
   output logic [uart_alu_pkg::NB_DATA-1:0] o_result
);

   import uart_alu_pkg::*;

   // Shift amount, low 3 bits of b
   logic [NB_BIT_CNT-1:0] shamt;

   assign shamt = i_req.b[NB_BIT_CNT-1:0];

   // Results wrap to 8 bits
   always_comb begin
      case (i_req.op)
         OP_ADD: o_result = i_req.a + i_req.b;
         OP_SUB: o_result = i_req.a - i_req.b;
         OP_AND: o_result = i_req.a & i_req.b;
         OP_OR:  o_result = i_req.a | i_req.b;
         OP_XOR: o_result = i_req.a ^ i_req.b;
         OP_NOR: o_result = ~(i_req.a | i_req.b);
         // Sign bit fills from the left
         OP_SRA: o_result = $unsigned($signed(i_req.a) >>> shamt);
         OP_SRL: o_result = i_req.a >> shamt;
         // Undefined codes
         default: o_result = '0;
      endcase
   end

endmodule

/* source/uart_alu_top.sv */
`timescale 1ns/10ps

module uart_alu_top (
   input  logic i_clk,
   input  logic i_rst_n,
   input  logic i_rx,
   output logic o_tx
);

   import uart_alu_pkg::*;

   // Oversampling tick to both UART halves
   logic               tick;
   // Receiver to sequencer
   logic [NB_DATA-1:0] rx_data;
   logic               rx_done;
   // Sequencer and ALU
   alu_req_t           alu_req;
   logic [NB_DATA-1:0] alu_result;
   // Sequencer and transmitter
   logic               tx_start;
   logic [NB_DATA-1:0] tx_data;
   logic               tx_busy;

   ////////////////////////////////////////////////////////////
   // Timing and serial front end
   ////////////////////////////////////////////////////////////

   baud_tick_gen u_baud_tick_gen (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .o_tick  (tick)
   );

   uart_rx u_uart_rx (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_tick  (tick),
      .i_rx    (i_rx),
      .o_data  (rx_data),
      .o_done  (rx_done)
   );

   ////////////////////////////////////////////////////////////
   // Command path
   ////////////////////////////////////////////////////////////

   alu_cmd_fsm u_alu_cmd_fsm (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_rx_data  (rx_data),
      .i_rx_done  (rx_done),
      .i_result   (alu_result),
      .i_tx_busy  (tx_busy),
      .o_req      (alu_req),
      .o_tx_start (tx_start),
      .o_tx_data  (tx_data)
   );

   alu u_alu (
      .i_req    (alu_req),
      .o_result (alu_result)
   );

   // Reply back to the host
   uart_tx u_uart_tx (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_tick  (tick),
      .i_start (tx_start),
      .i_data  (tx_data),
      .o_tx    (o_tx),
      .o_busy  (tx_busy)
   );

endmodule

/* test/uart_alu_tb.sv */
`timescale 1ns/10ps

module uart_alu_tb;

   import uart_alu_pkg::*;

   // Clocks per serial bit
   localparam int BIT_CLKS        = BAUD_DIVISOR * OVERSAMPLE;
   // Longest wait for outstanding replies in bit periods
   localparam int REPLY_WAIT_BITS = 60;
   localparam int STREAM_CMDS     = 100;

   logic i_clk;
   logic i_rst_n;
   logic i_rx;
   logic o_tx;

   logic [31:0]        rng_state;
   // Expected replies in send order and the test that sent each
   logic [NB_DATA-1:0] exp_q[$];
   string              name_q[$];

   uart_alu_top u_dut (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_rx    (i_rx),
      .o_tx    (o_tx)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic stop_run();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at first failure");
   endtask

   // LCG over a 32 bit state
   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic logic [NB_DATA-1:0] random_byte();
      logic [31:0] r;
      r = next_random();
      return r[23:16];
   endfunction

   function automatic logic [NB_OP-1:0] defined_op(int idx);
      case (idx)
         0:       return OP_ADD;
         1:       return OP_SUB;
         2:       return OP_AND;
         3:       return OP_OR;
         4:       return OP_XOR;
         5:       return OP_NOR;
         6:       return OP_SRA;
         default: return OP_SRL;
      endcase
   endfunction

   // Reference ALU with results wrapped to one byte
   function automatic logic [NB_DATA-1:0] expected_result(alu_req_t cmd);
      logic [NB_DATA:0]     sum;
      logic [2*NB_DATA-1:0] ext;
      int                   sh;
      sh = int'(cmd.b[2:0]);
      case (cmd.op)
         OP_ADD: sum = {1'b0, cmd.a} + {1'b0, cmd.b};
         // Two's complement subtract
         OP_SUB: sum = {1'b0, cmd.a} + {1'b0, ~cmd.b} + 9'd1;
         OP_AND: sum = {1'b0, cmd.a & cmd.b};
         OP_OR:  sum = {1'b0, cmd.a | cmd.b};
         OP_XOR: sum = {1'b0, cmd.a ^ cmd.b};
         OP_NOR: sum = {1'b0, ~cmd.a & ~cmd.b};
         OP_SRA: begin
            ext = {{NB_DATA{cmd.a[NB_DATA-1]}}, cmd.a} >> sh;
            sum = {1'b0, ext[NB_DATA-1:0]};
         end
         OP_SRL: sum = {1'b0, cmd.a >> sh};
         default: sum = '0;
      endcase
      return sum[NB_DATA-1:0];
   endfunction

   ////////////////////////////////////////////////////////////
   // Serial driver
   ////////////////////////////////////////////////////////////

   // Called on a rising edge and returns on one
   task automatic send_bit(logic level);
      i_rx <= level;
      repeat (BIT_CLKS) @(posedge i_clk);
   endtask

   // Bad stop is low for 3/4 bit so the rearmed receiver finds idle at mid start
   task automatic send_frame(logic [NB_DATA-1:0] data, bit good_stop);
      send_bit(1'b0);
      for (int i = 0; i < NB_DATA; i++) begin
         send_bit(data[i]);
      end
      if (good_stop) begin
         send_bit(1'b1);
      end else begin
         i_rx <= 1'b0;
         repeat (BIT_CLKS * 3 / 4) @(posedge i_clk);
         i_rx <= 1'b1;
         repeat (BIT_CLKS / 4) @(posedge i_clk);
      end
   endtask

   task automatic expect_reply(alu_req_t cmd, string name);
      exp_q.push_back(expected_result(cmd));
      name_q.push_back(name);
   endtask

   // Upper two bits of the op byte are random and must be ignored
   task automatic send_command(alu_req_t cmd, string name);
      logic [NB_DATA-1:0] hi;
      hi = random_byte();
      expect_reply(cmd, name);
      send_frame(cmd.a, 1'b1);
      send_frame(cmd.b, 1'b1);
      send_frame({hi[1:0], cmd.op}, 1'b1);
   endtask

   task automatic wait_for_replies(string name);
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         @(posedge i_clk);
         waited++;
         if (waited > REPLY_WAIT_BITS * BIT_CLKS) begin
            $display("Timeout in %s with %0d replies never received", name, exp_q.size());
            stop_run();
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Reply sampler
   ////////////////////////////////////////////////////////////

   // Entered half a clock into the start bit
   task automatic receive_reply(output logic [NB_DATA-1:0] data);
      repeat (BIT_CLKS / 2 - 1) @(negedge i_clk);
      assert (o_tx == 1'b0) else begin
         $display("Reply start bit was not low at mid-bit");
         stop_run();
      end
      for (int i = 0; i < NB_DATA; i++) begin
         repeat (BIT_CLKS) @(negedge i_clk);
         data[i] = o_tx;
      end
      repeat (BIT_CLKS) @(negedge i_clk);
      assert (o_tx == 1'b1) else begin
         $display("Reply stop bit sampled low");
         stop_run();
      end
   endtask

   task automatic check_reply(logic [NB_DATA-1:0] got);
      logic [NB_DATA-1:0] exp;
      string              name;
      assert (exp_q.size() > 0) else begin
         $display("Reply byte %h arrived with no command waiting for it", got);
         stop_run();
      end
      exp  = exp_q.pop_front();
      name = name_q.pop_front();
      assert (got == exp) else begin
         $display("error %s expected %h actual %h", name, exp, got);
         stop_run();
      end
   endtask

   initial begin : reply_monitor
      logic [NB_DATA-1:0] rx_byte;
      forever begin
         @(negedge i_clk);
         if (i_rst_n && !o_tx) begin
            receive_reply(rx_byte);
            check_reply(rx_byte);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin : main_seq
      alu_req_t cmd;
      rng_state = 32'h24b6a9d9;
      i_rx      = 1'b1;
      i_rst_n   = 1'b0;
      repeat (8) @(posedge i_clk);
      i_rst_n <= 1'b1;
      repeat (4) @(posedge i_clk);

      // Quiet line gives a quiet reply line
      for (int i = 0; i < 20 * BIT_CLKS; i++) begin
         @(negedge i_clk);
         assert (o_tx == 1'b1) else begin
            $display("error idle_line expected 1 actual %b", o_tx);
            stop_run();
         end
      end
      @(posedge i_clk);

      // Every defined opcode once
      for (int i = 0; i < 8; i++) begin
         cmd.a  = random_byte();
         cmd.b  = random_byte();
         cmd.op = defined_op(i);
         send_command(cmd, "opcode_sweep");
         wait_for_replies("opcode_sweep");
      end

      // Back to back commands overlap the previous reply
      for (int i = 0; i < STREAM_CMDS; i++) begin
         cmd.a  = random_byte();
         cmd.b  = random_byte();
         cmd.op = NB_OP'(random_byte() >> 2);
         // Half the stream uses defined codes
         if (cmd.op[0]) begin
            cmd.op = defined_op(int'(cmd.op[3:1]));
         end
         send_command(cmd, "random_stream");
      end
      wait_for_replies("random_stream");

      // Quarter bit start glitch
      i_rx <= 1'b0;
      repeat (BIT_CLKS / 4) @(posedge i_clk);
      i_rx <= 1'b1;
      repeat (2 * BIT_CLKS) @(posedge i_clk);
      cmd.a  = random_byte();
      cmd.b  = random_byte();
      cmd.op = OP_SUB;
      send_command(cmd, "start_glitch");
      wait_for_replies("start_glitch");

      // Framing error byte between A and B
      cmd.a  = random_byte();
      cmd.b  = random_byte();
      cmd.op = OP_XOR;
      expect_reply(cmd, "bad_stop");
      send_frame(cmd.a, 1'b1);
      send_frame(random_byte(), 1'b0);
      send_bit(1'b1);
      send_frame(cmd.b, 1'b1);
      send_frame({2'b00, cmd.op}, 1'b1);
      wait_for_replies("bad_stop");

      // Room for any stray byte to show up
      repeat (12 * BIT_CLKS) @(posedge i_clk);
      $display("Result: PASSED");
      $finish;
   end

endmodule

/* flist.f */
source/uart_alu_pkg.sv
source/baud_tick_gen.sv
source/uart_rx.sv
source/uart_tx.sv
source/alu_cmd_fsm.sv
source/alu.sv
source/uart_alu_top.sv
test/uart_alu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UART ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_TEXT="Result: FAILED"

rm -rf obj_dir

# Build, then run only if the build succeeded
verilator --binary --timing --assert -Wno-fatal \
   -f flist.f --top-module uart_alu_tb -o uart_alu_sim > "$LOG" 2>&1 \
   && ./obj_dir/uart_alu_sim >> "$LOG" 2>&1
run_status=$?

cat "$LOG"

grep -q "$FAIL_TEXT" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
[ "$run_status" -eq 0 ] || { echo "Build or run did not complete, see $LOG"; exit 1; }

echo "Simulation finished without failures"
exit 0
